//--- rtl/rv_core_pkg.sv
package rv_core_pkg;

    localparam int XLEN = 32;
    localparam int REG_ADDR_W = 5;

    // addi x0, x0, 0
    localparam logic [XLEN-1:0] NOP_INSTR = 32'h0000_0013;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    // ALU operand A
    localparam logic [1:0] SRC_A_RS1  = 2'd0;
    localparam logic [1:0] SRC_A_PC   = 2'd1;
    localparam logic [1:0] SRC_A_ZERO = 2'd2;

    // ALU operand B
    localparam logic [2:0] SRC_B_RS2  = 3'd0;
    localparam logic [2:0] SRC_B_IMM  = 3'd1;
    localparam logic [2:0] SRC_B_FOUR = 3'd2;

    // what execute reports as its result
    localparam logic [2:0] WB_SEL_ALU       = 3'd0;
    localparam logic [2:0] WB_SEL_PC_PLUS_4 = 3'd1;

endpackage

//--- rtl/instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder (
    input  logic [rv_core_pkg::XLEN-1:0]       instruction,
    output logic [6:0]                         opcode,
    output logic [2:0]                         funct3,
    output logic [6:0]                         funct7,
    output logic [rv_core_pkg::REG_ADDR_W-1:0] rd,
    output logic [rv_core_pkg::REG_ADDR_W-1:0] rs1,
    output logic [rv_core_pkg::REG_ADDR_W-1:0] rs2,
    output logic [rv_core_pkg::XLEN-1:0]       imm,
    output logic [1:0]                         alu_src_a_select,
    output logic [2:0]                         alu_src_b_select,
    output logic [2:0]                         result_select,
    output logic                               register_write_enable,
    output logic                               branch,
    output logic                               jump
);

    logic [rv_core_pkg::XLEN-1:0] imm_i;
    logic [rv_core_pkg::XLEN-1:0] imm_u;
    logic [rv_core_pkg::XLEN-1:0] imm_j;
    logic [rv_core_pkg::XLEN-1:0] imm_b;

    assign opcode = instruction[6:0];
    assign rd     = instruction[11:7];
    assign funct3 = instruction[14:12];
    assign rs1    = instruction[19:15];
    assign rs2    = instruction[24:20];
    assign funct7 = instruction[31:25];

    // immediates per format, all sign extended from bit 31
    assign imm_i = {{20{instruction[31]}}, instruction[31:20]};
    assign imm_u = {instruction[31:12], 12'b0};
    assign imm_j = {{12{instruction[31]}}, instruction[19:12], instruction[20],
                    instruction[30:21], 1'b0};
    assign imm_b = {{20{instruction[31]}}, instruction[7], instruction[30:25],
                    instruction[11:8], 1'b0};

    always_comb begin
        alu_src_a_select      = rv_core_pkg::SRC_A_RS1;
        alu_src_b_select      = rv_core_pkg::SRC_B_RS2;
        result_select         = rv_core_pkg::WB_SEL_ALU;
        register_write_enable = 1'b0;
        branch                = 1'b0;
        jump                  = 1'b0;
        imm                   = '0;
        case (opcode)
            rv_core_pkg::OPC_OP: begin
                register_write_enable = 1'b1;
            end
            rv_core_pkg::OPC_OP_IMM: begin
                alu_src_b_select      = rv_core_pkg::SRC_B_IMM;
                register_write_enable = 1'b1;
                imm                   = imm_i;
            end
            rv_core_pkg::OPC_LUI: begin
                alu_src_a_select      = rv_core_pkg::SRC_A_ZERO;
                alu_src_b_select      = rv_core_pkg::SRC_B_IMM;
                register_write_enable = 1'b1;
                imm                   = imm_u;
            end
            rv_core_pkg::OPC_AUIPC: begin
                alu_src_a_select      = rv_core_pkg::SRC_A_PC;
                alu_src_b_select      = rv_core_pkg::SRC_B_IMM;
                register_write_enable = 1'b1;
                imm                   = imm_u;
            end
            rv_core_pkg::OPC_JAL,
            rv_core_pkg::OPC_JALR: begin
                // link value is pc + 4
                alu_src_a_select      = rv_core_pkg::SRC_A_PC;
                alu_src_b_select      = rv_core_pkg::SRC_B_FOUR;
                result_select         = rv_core_pkg::WB_SEL_PC_PLUS_4;
                register_write_enable = 1'b1;
                jump                  = 1'b1;
                imm                   = (opcode == rv_core_pkg::OPC_JAL) ? imm_j : imm_i;
            end
            rv_core_pkg::OPC_BRANCH: begin
                branch = 1'b1;
                imm    = imm_b;
            end
            default: begin
                // unknown opcode behaves as a bubble
                imm = '0;
            end
        endcase
    end

endmodule

//--- rtl/register_file.sv
`timescale 1ns/1ps

module register_file (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               write_enable,
    input  logic [rv_core_pkg::REG_ADDR_W-1:0] write_addr,
    input  logic [rv_core_pkg::XLEN-1:0]       write_data,
    input  logic [rv_core_pkg::REG_ADDR_W-1:0] read_addr1,
    input  logic [rv_core_pkg::REG_ADDR_W-1:0] read_addr2,
    output logic [rv_core_pkg::XLEN-1:0]       read_data1,
    output logic [rv_core_pkg::XLEN-1:0]       read_data2
);

    logic [rv_core_pkg::XLEN-1:0] regs [2**rv_core_pkg::REG_ADDR_W];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 2**rv_core_pkg::REG_ADDR_W; i++) begin
                regs[i] <= '0;
            end
        end else if (write_enable && write_addr != '0) begin
            regs[write_addr] <= write_data;
        end
    end

    // x0 reads as zero, no write bypass
    assign read_data1 = (read_addr1 == '0) ? '0 : regs[read_addr1];
    assign read_data2 = (read_addr2 == '0) ? '0 : regs[read_addr2];

endmodule

//--- rtl/id_ex_register.sv
`timescale 1ns/1ps

module id_ex_register (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               flush,

    input  logic [rv_core_pkg::XLEN-1:0]       id_pc,
    input  logic [rv_core_pkg::XLEN-1:0]       id_pc_plus_4,
    input  logic [rv_core_pkg::XLEN-1:0]       id_instruction,
    input  logic                               id_branch_prediction,
    input  logic                               id_jump,
    input  logic                               id_branch,
    input  logic [1:0]                         id_alu_src_a_select,
    input  logic [2:0]                         id_alu_src_b_select,
    input  logic [2:0]                         id_result_select,
    input  logic                               id_register_write_enable,
    input  logic [2:0]                         id_funct3,
    input  logic [6:0]                         id_funct7,
    input  logic [rv_core_pkg::REG_ADDR_W-1:0] id_rd,
    input  logic [rv_core_pkg::XLEN-1:0]       id_read_data1,
    input  logic [rv_core_pkg::XLEN-1:0]       id_read_data2,
    input  logic [rv_core_pkg::XLEN-1:0]       id_imm,

    output logic [rv_core_pkg::XLEN-1:0]       ex_pc,
    output logic [rv_core_pkg::XLEN-1:0]       ex_pc_plus_4,
    output logic [rv_core_pkg::XLEN-1:0]       ex_instruction,
    output logic                               ex_branch_prediction,
    output logic                               ex_jump,
    output logic                               ex_branch,
    output logic [1:0]                         ex_alu_src_a_select,
    output logic [2:0]                         ex_alu_src_b_select,
    output logic [2:0]                         ex_result_select,
    output logic                               ex_register_write_enable,
    output logic [2:0]                         ex_funct3,
    output logic [6:0]                         ex_funct7,
    output logic [rv_core_pkg::REG_ADDR_W-1:0] ex_rd,
    output logic [rv_core_pkg::XLEN-1:0]       ex_read_data1,
    output logic [rv_core_pkg::XLEN-1:0]       ex_read_data2,
    output logic [rv_core_pkg::XLEN-1:0]       ex_imm
);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ex_pc                    <= '0;
            ex_pc_plus_4             <= '0;
            ex_instruction           <= rv_core_pkg::NOP_INSTR;
            ex_branch_prediction     <= 1'b0;
            ex_jump                  <= 1'b0;
            ex_branch                <= 1'b0;
            ex_alu_src_a_select      <= '0;
            ex_alu_src_b_select      <= '0;
            ex_result_select         <= '0;
            ex_register_write_enable <= 1'b0;
            ex_funct3                <= '0;
            ex_funct7                <= '0;
            ex_rd                    <= '0;
            ex_read_data1            <= '0;
            ex_read_data2            <= '0;
            ex_imm                   <= '0;
        end else begin
            // flush loads the same bubble as reset
            ex_pc                    <= flush ? '0 : id_pc;
            ex_pc_plus_4             <= flush ? '0 : id_pc_plus_4;
            ex_instruction           <= flush ? rv_core_pkg::NOP_INSTR : id_instruction;
            ex_branch_prediction     <= flush ? 1'b0 : id_branch_prediction;
            ex_jump                  <= flush ? 1'b0 : id_jump;
            ex_branch                <= flush ? 1'b0 : id_branch;
            ex_alu_src_a_select      <= flush ? '0 : id_alu_src_a_select;
            ex_alu_src_b_select      <= flush ? '0 : id_alu_src_b_select;
            ex_result_select         <= flush ? '0 : id_result_select;
            ex_register_write_enable <= flush ? 1'b0 : id_register_write_enable;
            ex_funct3                <= flush ? '0 : id_funct3;
            ex_funct7                <= flush ? '0 : id_funct7;
            ex_rd                    <= flush ? '0 : id_rd;
            ex_read_data1            <= flush ? '0 : id_read_data1;
            ex_read_data2            <= flush ? '0 : id_read_data2;
            ex_imm                   <= flush ? '0 : id_imm;
        end
    end

endmodule

//--- rtl/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
    input  logic                               clk,
    input  logic                               reset,
    input  logic [rv_core_pkg::XLEN-1:0]       ex_pc,
    input  logic [rv_core_pkg::XLEN-1:0]       ex_pc_plus_4,
    input  logic [rv_core_pkg::XLEN-1:0]       ex_instruction,
    input  logic                               ex_branch_prediction,
    input  logic                               ex_jump,
    input  logic                               ex_branch,
    input  logic [1:0]                         ex_alu_src_a_select,
    input  logic [2:0]                         ex_alu_src_b_select,
    input  logic [2:0]                         ex_result_select,
    input  logic                               ex_register_write_enable,
    input  logic [2:0]                         ex_funct3,
    input  logic [6:0]                         ex_funct7,
    input  logic [rv_core_pkg::REG_ADDR_W-1:0] ex_rd,
    input  logic [rv_core_pkg::XLEN-1:0]       ex_read_data1,
    input  logic [rv_core_pkg::XLEN-1:0]       ex_read_data2,
    input  logic [rv_core_pkg::XLEN-1:0]       ex_imm,
    output logic                               valid_write,
    output logic [rv_core_pkg::REG_ADDR_W-1:0] rd,
    output logic [rv_core_pkg::XLEN-1:0]       result,
    output logic                               redirect,
    output logic [rv_core_pkg::XLEN-1:0]       target,
    output logic                               mispredict
);

    logic [6:0]                   opcode;
    logic [rv_core_pkg::XLEN-1:0] op_a;
    logic [rv_core_pkg::XLEN-1:0] op_b;
    logic [rv_core_pkg::XLEN-1:0] alu_out;
    logic [rv_core_pkg::XLEN-1:0] jalr_sum;
    logic [rv_core_pkg::XLEN-1:0] target_next;
    logic                         taken;

    assign opcode = ex_instruction[6:0];

    always_comb begin
        case (ex_alu_src_a_select)
            rv_core_pkg::SRC_A_RS1: op_a = ex_read_data1;
            rv_core_pkg::SRC_A_PC:  op_a = ex_pc;
            default:                op_a = '0;
        endcase
        case (ex_alu_src_b_select)
            rv_core_pkg::SRC_B_RS2:  op_b = ex_read_data2;
            rv_core_pkg::SRC_B_IMM:  op_b = ex_imm;
            rv_core_pkg::SRC_B_FOUR: op_b = 4;
            default:                 op_b = '0;
        endcase
    end

    // only OP and OP-IMM pick an operation by funct3; other opcodes add
    always_comb begin
        alu_out = op_a + op_b;
        if (opcode == rv_core_pkg::OPC_OP || opcode == rv_core_pkg::OPC_OP_IMM) begin
            case (ex_funct3)
                3'b000: begin
                    if (opcode == rv_core_pkg::OPC_OP && ex_funct7[5]) begin
                        alu_out = op_a - op_b;
                    end
                end
                3'b001: alu_out = op_a << op_b[4:0];
                3'b010: alu_out = {{(rv_core_pkg::XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
                3'b011: alu_out = {{(rv_core_pkg::XLEN-1){1'b0}}, op_a < op_b};
                3'b100: alu_out = op_a ^ op_b;
                3'b101: begin
                    if (ex_funct7[5]) begin
                        alu_out = $signed(op_a) >>> op_b[4:0];
                    end else begin
                        alu_out = op_a >> op_b[4:0];
                    end
                end
                3'b110: alu_out = op_a | op_b;
                default: alu_out = op_a & op_b;
            endcase
        end
    end

    always_comb begin
        case (ex_funct3)
            3'b000:  taken = ex_read_data1 == ex_read_data2;
            3'b001:  taken = ex_read_data1 != ex_read_data2;
            3'b100:  taken = $signed(ex_read_data1) < $signed(ex_read_data2);
            3'b101:  taken = $signed(ex_read_data1) >= $signed(ex_read_data2);
            3'b110:  taken = ex_read_data1 < ex_read_data2;
            3'b111:  taken = ex_read_data1 >= ex_read_data2;
            default: taken = 1'b0;
        endcase
    end

    assign jalr_sum    = ex_read_data1 + ex_imm;
    assign target_next = (opcode == rv_core_pkg::OPC_JALR)
                       ? {jalr_sum[rv_core_pkg::XLEN-1:1], 1'b0}
                       : ex_pc + ex_imm;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            valid_write <= 1'b0;
            rd          <= '0;
            result      <= '0;
            redirect    <= 1'b0;
            target      <= '0;
            mispredict  <= 1'b0;
        end else begin
            valid_write <= ex_register_write_enable;
            rd          <= ex_rd;
            result      <= (ex_result_select == rv_core_pkg::WB_SEL_PC_PLUS_4) ? ex_pc_plus_4
                                                                                : alu_out;
            redirect    <= ex_jump || (ex_branch && taken);
            target      <= target_next;
            // jumps are never predicted here, so any jump counts as a miss
            mispredict  <= ex_branch ? (taken ^ ex_branch_prediction) : ex_jump;
        end
    end

endmodule

//--- rtl/decode_execute_top.sv
`timescale 1ns/1ps

module decode_execute_top (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               flush,
    input  logic [rv_core_pkg::XLEN-1:0]       id_pc,
    input  logic [rv_core_pkg::XLEN-1:0]       id_instruction,
    input  logic                               id_branch_prediction,
    input  logic                               wb_enable,
    input  logic [rv_core_pkg::REG_ADDR_W-1:0] wb_rd,
    input  logic [rv_core_pkg::XLEN-1:0]       wb_data,
    output logic                               ex_valid_write,
    output logic [rv_core_pkg::REG_ADDR_W-1:0] ex_rd,
    output logic [rv_core_pkg::XLEN-1:0]       ex_result,
    output logic                               ex_redirect,
    output logic [rv_core_pkg::XLEN-1:0]       ex_target,
    output logic                               ex_mispredict
);

    // decode side
    logic [rv_core_pkg::XLEN-1:0]       id_pc_plus_4;
    logic [rv_core_pkg::XLEN-1:0]       id_read_data1, id_read_data2, id_imm;
    logic [rv_core_pkg::REG_ADDR_W-1:0] id_rd, id_rs1, id_rs2;
    logic [2:0]                         id_funct3, id_alu_src_b_select, id_result_select;
    logic [6:0]                         id_funct7;
    logic [1:0]                         id_alu_src_a_select;
    logic                               id_register_write_enable, id_branch, id_jump;

    // execute side, rd is renamed since the top output takes ex_rd
    logic [rv_core_pkg::XLEN-1:0]       ex_pc, ex_pc_plus_4, ex_instruction;
    logic [rv_core_pkg::XLEN-1:0]       ex_read_data1, ex_read_data2, ex_imm;
    logic [rv_core_pkg::REG_ADDR_W-1:0] idex_rd;
    logic [2:0]                         ex_funct3, ex_alu_src_b_select, ex_result_select;
    logic [6:0]                         ex_funct7;
    logic [1:0]                         ex_alu_src_a_select;
    logic                               ex_branch_prediction, ex_jump, ex_branch;
    logic                               ex_register_write_enable;

    assign id_pc_plus_4 = id_pc + 4;

    instr_decoder instr_decoder_i (
        .instruction           (id_instruction),
        .opcode                (),
        .funct3                (id_funct3),
        .funct7                (id_funct7),
        .rd                    (id_rd),
        .rs1                   (id_rs1),
        .rs2                   (id_rs2),
        .imm                   (id_imm),
        .alu_src_a_select      (id_alu_src_a_select),
        .alu_src_b_select      (id_alu_src_b_select),
        .result_select         (id_result_select),
        .register_write_enable (id_register_write_enable),
        .branch                (id_branch),
        .jump                  (id_jump)
    );

    register_file register_file_i (
        .clk          (clk),
        .reset        (reset),
        .write_enable (wb_enable),
        .write_addr   (wb_rd),
        .write_data   (wb_data),
        .read_addr1   (id_rs1),
        .read_addr2   (id_rs2),
        .read_data1   (id_read_data1),
        .read_data2   (id_read_data2)
    );

    id_ex_register id_ex_register_i (
        .ex_rd (idex_rd),
        .*
    );

    execute_stage execute_stage_i (
        .ex_rd       (idex_rd),
        .valid_write (ex_valid_write),
        .rd          (ex_rd),
        .result      (ex_result),
        .redirect    (ex_redirect),
        .target      (ex_target),
        .mispredict  (ex_mispredict),
        .*
    );

endmodule

//--- verification/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic reset
);

    // 10 ns period
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // reset held for the first 4 rising edges
    initial begin
        reset = 1'b1;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

//--- verification/decode_execute_tb.sv
`timescale 1ns/1ps

module decode_execute_tb;

    localparam int NUM_ROWS      = 22;
    localparam int RESET_TIMEOUT = 50;

    logic                               clk;
    logic                               reset;
    logic                               flush;
    logic [rv_core_pkg::XLEN-1:0]       id_pc;
    logic [rv_core_pkg::XLEN-1:0]       id_instruction;
    logic                               id_branch_prediction;
    logic                               wb_enable;
    logic [rv_core_pkg::REG_ADDR_W-1:0] wb_rd;
    logic [rv_core_pkg::XLEN-1:0]       wb_data;
    logic                               ex_valid_write;
    logic [rv_core_pkg::REG_ADDR_W-1:0] ex_rd;
    logic [rv_core_pkg::XLEN-1:0]       ex_result;
    logic                               ex_redirect;
    logic [rv_core_pkg::XLEN-1:0]       ex_target;
    logic                               ex_mispredict;

    // stimulus and expected outputs, one row per instruction
    logic [31:0] row_pc         [NUM_ROWS];
    logic [31:0] row_instr      [NUM_ROWS];
    logic        row_pred       [NUM_ROWS];
    logic        row_flush      [NUM_ROWS];
    logic        exp_vw         [NUM_ROWS];
    logic [4:0]  exp_rd         [NUM_ROWS];
    logic [31:0] exp_result     [NUM_ROWS];
    logic        exp_redirect   [NUM_ROWS];
    logic        chk_target     [NUM_ROWS];
    logic [31:0] exp_target     [NUM_ROWS];
    logic        exp_mispredict [NUM_ROWS];

    int row_count   = 0;
    int error_count = 0;

    tb_clock_gen clock_gen_i (
        .clk   (clk),
        .reset (reset)
    );

    decode_execute_top decode_execute_top_i (
        .clk                  (clk),
        .reset                (reset),
        .flush                (flush),
        .id_pc                (id_pc),
        .id_instruction       (id_instruction),
        .id_branch_prediction (id_branch_prediction),
        .wb_enable            (wb_enable),
        .wb_rd                (wb_rd),
        .wb_data              (wb_data),
        .ex_valid_write       (ex_valid_write),
        .ex_rd                (ex_rd),
        .ex_result            (ex_result),
        .ex_redirect          (ex_redirect),
        .ex_target            (ex_target),
        .ex_mispredict        (ex_mispredict)
    );

    // RV32I instruction formats
    function automatic logic [31:0] r_type_word(input logic [6:0] f7, input logic [4:0] rs2,
                                                input logic [4:0] rs1, input logic [2:0] f3,
                                                input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, rv_core_pkg::OPC_OP};
    endfunction

    function automatic logic [31:0] i_type_word(input logic [11:0] imm, input logic [4:0] rs1,
                                                input logic [2:0] f3, input logic [4:0] rd,
                                                input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] u_type_word(input logic [19:0] imm, input logic [4:0] rd,
                                                input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] jal_word(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_core_pkg::OPC_JAL};
    endfunction

    function automatic logic [31:0] branch_word(input logic [12:0] imm, input logic [4:0] rs2,
                                                input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_core_pkg::OPC_BRANCH};
    endfunction

    // pc steps by 4 from 0x100
    task automatic add_row(input logic [31:0] instr, input logic pred, input logic flsh,
                           input logic vw, input logic [4:0] rd, input logic [31:0] result,
                           input logic redirect, input logic tgt_on, input logic [31:0] target,
                           input logic mispredict);
        row_pc[row_count]         = 32'h100 + 4 * row_count;
        row_instr[row_count]      = instr;
        row_pred[row_count]       = pred;
        row_flush[row_count]      = flsh;
        exp_vw[row_count]         = vw;
        exp_rd[row_count]         = rd;
        exp_result[row_count]     = result;
        exp_redirect[row_count]   = redirect;
        chk_target[row_count]     = tgt_on;
        exp_target[row_count]     = target;
        exp_mispredict[row_count] = mispredict;
        row_count++;
    endtask

    task automatic build_table();
        // x1=7, x2=-16, x3=7, x4=0x8000_0000
        add_row(r_type_word(7'h00, 5'd2, 5'd1, 3'b000, 5'd5), 1'b0, 1'b0,
                1'b1, 5'd5, 32'hFFFF_FFF7, 1'b0, 1'b0, 32'h0, 1'b0);
        add_row(r_type_word(7'h20, 5'd2, 5'd1, 3'b000, 5'd6), 1'b0, 1'b0,
                1'b1, 5'd6, 32'h0000_0017, 1'b0, 1'b0, 32'h0, 1'b0);
        add_row(r_type_word(7'h00, 5'd2, 5'd1, 3'b010, 5'd7), 1'b0, 1'b0,
                1'b1, 5'd7, 32'h0000_0000, 1'b0, 1'b0, 32'h0, 1'b0);
        add_row(r_type_word(7'h00, 5'd2, 5'd1, 3'b011, 5'd8), 1'b0, 1'b0,
                1'b1, 5'd8, 32'h0000_0001, 1'b0, 1'b0, 32'h0, 1'b0);
        add_row(i_type_word(12'h402, 5'd2, 3'b101, 5'd9, rv_core_pkg::OPC_OP_IMM), 1'b0, 1'b0,
                1'b1, 5'd9, 32'hFFFF_FFFC, 1'b0, 1'b0, 32'h0, 1'b0);
        add_row(r_type_word(7'h00, 5'd4, 5'd1, 3'b100, 5'd10), 1'b0, 1'b0,
                1'b1, 5'd10, 32'h8000_0007, 1'b0, 1'b0, 32'h0, 1'b0);
        add_row(i_type_word(12'h004, 5'd1, 3'b001, 5'd11, rv_core_pkg::OPC_OP_IMM), 1'b0, 1'b0,
                1'b1, 5'd11, 32'h0000_0070, 1'b0, 1'b0, 32'h0, 1'b0);
        add_row(i_type_word(12'h005, 5'd1, 3'b000, 5'd0, rv_core_pkg::OPC_OP_IMM), 1'b0, 1'b0,
                1'b1, 5'd0, 32'h0000_000C, 1'b0, 1'b0, 32'h0, 1'b0);
        add_row(u_type_word(20'h12345, 5'd12, rv_core_pkg::OPC_LUI), 1'b0, 1'b0,
                1'b1, 5'd12, 32'h1234_5000, 1'b0, 1'b0, 32'h0, 1'b0);
        add_row(u_type_word(20'h00001, 5'd13, rv_core_pkg::OPC_AUIPC), 1'b0, 1'b0,
                1'b1, 5'd13, 32'h0000_1124, 1'b0, 1'b0, 32'h0, 1'b0);
        add_row(jal_word(21'h40, 5'd1), 1'b0, 1'b0,
                1'b1, 5'd1, 32'h0000_012C, 1'b1, 1'b1, 32'h0000_0168, 1'b1);
        // x1 + 4 is odd, low bit of the target drops
        add_row(i_type_word(12'h004, 5'd1, 3'b000, 5'd14, rv_core_pkg::OPC_JALR), 1'b0, 1'b0,
                1'b1, 5'd14, 32'h0000_0130, 1'b1, 1'b1, 32'h0000_000A, 1'b1);
        add_row(branch_word(13'h010, 5'd3, 5'd1, 3'b000), 1'b1, 1'b0,
                1'b0, 5'd0, 32'h0, 1'b1, 1'b1, 32'h0000_0140, 1'b0);
        add_row(branch_word(13'h010, 5'd3, 5'd1, 3'b000), 1'b0, 1'b0,
                1'b0, 5'd0, 32'h0, 1'b1, 1'b1, 32'h0000_0144, 1'b1);
        add_row(branch_word(13'h008, 5'd3, 5'd1, 3'b001), 1'b0, 1'b0,
                1'b0, 5'd0, 32'h0, 1'b0, 1'b1, 32'h0000_0140, 1'b0);
        add_row(branch_word(13'h008, 5'd3, 5'd1, 3'b001), 1'b1, 1'b0,
                1'b0, 5'd0, 32'h0, 1'b0, 1'b1, 32'h0000_0144, 1'b1);
        add_row(branch_word(13'h1FE0, 5'd1, 5'd2, 3'b100), 1'b1, 1'b0,
                1'b0, 5'd0, 32'h0, 1'b1, 1'b1, 32'h0000_0120, 1'b0);
        add_row(branch_word(13'h00C, 5'd1, 5'd2, 3'b111), 1'b0, 1'b0,
                1'b0, 5'd0, 32'h0, 1'b1, 1'b1, 32'h0000_0150, 1'b1);
        // flushed addi turns into an all zero bubble
        add_row(i_type_word(12'h001, 5'd1, 3'b000, 5'd15, rv_core_pkg::OPC_OP_IMM), 1'b0, 1'b1,
                1'b0, 5'd0, 32'h0, 1'b0, 1'b1, 32'h0, 1'b0);
        add_row(i_type_word(12'h001, 5'd1, 3'b000, 5'd15, rv_core_pkg::OPC_OP_IMM), 1'b0, 1'b0,
                1'b1, 5'd15, 32'h0000_0008, 1'b0, 1'b0, 32'h0, 1'b0);
        // drain
        add_row(rv_core_pkg::NOP_INSTR, 1'b0, 1'b0, 1'b1, 5'd0, 32'h0, 1'b0, 1'b0, 32'h0, 1'b0);
        add_row(rv_core_pkg::NOP_INSTR, 1'b0, 1'b0, 1'b1, 5'd0, 32'h0, 1'b0, 1'b0, 32'h0, 1'b0);
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("ERROR at %0t ns: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
            error_count++;
        end
    endtask

    task automatic check_row(input int r);
        string tag;
        tag = $sformatf("row %0d", r);
        check_value({tag, " valid_write"}, 32'(ex_valid_write), 32'(exp_vw[r]));
        // rd and result only mean something for writes and bubbles
        if (exp_vw[r] || row_flush[r]) begin
            check_value({tag, " rd"}, 32'(ex_rd), 32'(exp_rd[r]));
            check_value({tag, " result"}, ex_result, exp_result[r]);
        end
        check_value({tag, " redirect"}, 32'(ex_redirect), 32'(exp_redirect[r]));
        check_value({tag, " mispredict"}, 32'(ex_mispredict), 32'(exp_mispredict[r]));
        if (chk_target[r]) begin
            check_value({tag, " target"}, ex_target, exp_target[r]);
        end
    endtask

    task automatic write_register(input logic [4:0] addr, input logic [31:0] data);
        wb_enable <= 1'b1;
        wb_rd     <= addr;
        wb_data   <= data;
        @(posedge clk);
    endtask

    task automatic apply_row(input int r);
        id_pc                <= row_pc[r];
        id_instruction       <= row_instr[r];
        id_branch_prediction <= row_pred[r];
        flush                <= row_flush[r];
    endtask

    initial begin
        int waited;
        flush                = 1'b0;
        id_pc                = '0;
        id_instruction       = rv_core_pkg::NOP_INSTR;
        id_branch_prediction = 1'b0;
        wb_enable            = 1'b0;
        wb_rd                = '0;
        wb_data              = '0;
        build_table();

        // outputs while reset is held
        @(negedge clk);
        check_value("reset valid_write", 32'(ex_valid_write), 32'h0);
        check_value("reset redirect", 32'(ex_redirect), 32'h0);
        check_value("reset mispredict", 32'(ex_mispredict), 32'h0);
        check_value("reset result", ex_result, 32'h0);

        waited = 0;
        while (reset && waited < RESET_TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (reset) begin
            $display("reset was still asserted after %0d cycles", RESET_TIMEOUT);
            $display("TEST FAILED");
            $finish;
        end else begin
            write_register(5'd1, 32'h0000_0007);
            write_register(5'd2, 32'hFFFF_FFF0);
            write_register(5'd3, 32'h0000_0007);
            write_register(5'd4, 32'h8000_0000);
            wb_enable <= 1'b0;

            // each row shows up two edges after it is driven
            for (int i = 0; i < NUM_ROWS; i++) begin
                apply_row(i);
                @(negedge clk);
                if (i >= 2) begin
                    check_row(i - 2);
                end
                @(posedge clk);
            end

            $display("run finished with %0d errors", error_count);
            if (error_count == 0) begin
                $display("TEST OK");
            end else begin
                $display("TEST FAILED");
            end
            $finish;
        end
    end

endmodule

//--- filelist.f
rtl/rv_core_pkg.sv
rtl/instr_decoder.sv
rtl/register_file.sv
rtl/id_ex_register.sv
rtl/execute_stage.sv
rtl/decode_execute_top.sv
verification/tb_clock_gen.sv
verification/decode_execute_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the decode/execute testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f \
    --top-module decode_execute_tb -Mdir obj_dir -o decode_execute_sim
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/decode_execute_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAILED" sim.log; then
    exit 1
fi
if ! grep -q "TEST OK" sim.log; then
    echo "no result line found in sim.log"
    exit 1
fi
exit 0
